//--- compile.f
trace_pkg.sv
trace_capture.sv
trace_decode.sv
trace_pack.sv
trace_unit_top.sv
trace_unit_properties.sv
tb_trace_unit.sv

//--- run.sh
#!/bin/sh
# build and run the trace unit simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_trace_unit \
  -o sim_trace_unit

./obj_dir/sim_trace_unit | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
grep -q "TEST PASSED" sim.log

//--- tb_trace_unit.sv
// trace unit testbench
`timescale 1ns/1ps

module tb_trace_unit import trace_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk;
  logic       rst_n;
  word_t      pc;
  word_t      instr;
  logic       id_valid;
  logic       is_decoding;
  logic       pipe_flush;
  word_t      rs1_value;
  word_t      rs2_value;
  word_t      rs3_value;
  trace_rec_t trace;
  logic       trace_valid;

  // reference state
  logic [31:0] lfsr_state = 32'h3f7;
  word_t       pc_next = 32'h0000_1000;
  logic        flush_mode = 1'b0;
  cycle_t      ref_cycle;
  trace_rec_t  pend_q[$];
  trace_rec_t  exp_q[$];
  cycle_t      due_q[$];
  int          run_cycles = 0;
  int          checked = 0;
  int          errors = 0;
  int          test_num = 0;
  int          test_checked = 0;
  int          test_errors = 0;

  trace_unit_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc          (pc),
    .instr       (instr),
    .id_valid    (id_valid),
    .is_decoding (is_decoding),
    .pipe_flush  (pipe_flush),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .rs3_value   (rs3_value),
    .trace       (trace),
    .trace_valid (trace_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // cycle count as the unit should stamp it
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_cycle <= '0;
    end else begin
      ref_cycle <= ref_cycle + 32'd1;
    end
  end

  always @(posedge clk) begin
    run_cycles <= run_cycles + 1;
  end

  initial begin
    wait (run_cycles >= TIMEOUT_CYCLES);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // random values and encoders
  ////////////////////////////////////////
  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function word_t rand_word();
    word_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input reg_id_t rs2, input reg_id_t rs1);
    return {f7, rs2, rs1, f3, 5'd7, OPC_OP};
  endfunction

  function automatic word_t enc_i(input int imm, input logic [2:0] f3,
                                  input reg_id_t rs1, input opcode_t opc);
    return {imm[11:0], rs1, f3, 5'd7, opc};
  endfunction

  function automatic word_t enc_s(input int imm, input logic [2:0] f3,
                                  input reg_id_t rs2, input reg_id_t rs1);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(input int imm, input logic [2:0] f3,
                                  input reg_id_t rs2, input reg_id_t rs1);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input opcode_t opc);
    return {imm, 5'd7, opc};
  endfunction

  function automatic word_t enc_j(input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
  endfunction

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////
  // one instruction in decode, with the record it should produce
  task automatic send(input word_t w, input mnem_t m, input fmt_t f, input word_t imm);
    trace_rec_t r;
    word_t      v1;
    word_t      v2;
    word_t      v3;
    v1 = rand_word();
    v2 = rand_word();
    v3 = rand_word();
    r = '0;
    r.pc    = pc_next;
    r.instr = w;
    r.mnem  = m;
    r.fmt   = f;
    r.imm   = imm;
    case (f)
      FMT_R, FMT_SB: begin
        r.nregs = 2'd2;
        r.regs0 = '{w[19:15], v1};
        r.regs1 = '{w[24:20], v2};
      end
      FMT_I, FMT_CSR_REG, FMT_LOAD: begin
        r.nregs = 2'd1;
        r.regs0 = '{w[19:15], v1};
      end
      FMT_STORE: begin
        r.nregs = 2'd2;
        r.regs0 = '{w[24:20], v2};
        r.regs1 = '{w[19:15], v1};
      end
      default: r.nregs = 2'd0;
    endcase
    if (f == FMT_SB || f == FMT_UJ) r.target = pc_next + imm;
    pend_q.push_back(r);
    @(posedge clk);
    pc          <= pc_next;
    instr       <= w;
    id_valid    <= !flush_mode;
    is_decoding <= !flush_mode;
    pipe_flush  <= flush_mode;
    rs1_value   <= v1;
    rs2_value   <= v2;
    rs3_value   <= v3;
    pc_next = pc_next + 32'd4;
  endtask

  task automatic idle();
    @(posedge clk);
    id_valid    <= 1'b0;
    is_decoding <= 1'b0;
    pipe_flush  <= 1'b0;
  endtask

  // valid in decode but stalled, so nothing is traced
  task automatic stall();
    @(posedge clk);
    instr       <= rand_word();
    id_valid    <= 1'b1;
    is_decoding <= 1'b0;
    pipe_flush  <= 1'b0;
  endtask

  task automatic check_field(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (exp === act) else begin
      $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    idle();
    while (exp_q.size() != 0 || pend_q.size() != 0) @(posedge clk);
    // records take three edges, so four more expose a stray strobe
    repeat (4) @(posedge clk);
    test_num++;
    $display("test %0d %s: %0d records checked, %0d errors", test_num, name,
             checked - test_checked, errors - test_errors);
    test_checked = checked;
    test_errors  = errors;
  endtask

  ////////////////////////////////////////
  // capture model and record checks
  ////////////////////////////////////////
  always @(posedge clk) begin : record_monitor
    trace_rec_t r;
    cycle_t     due;
    if (rst_n) begin
      if ((id_valid && is_decoding) || pipe_flush) begin
        if (pend_q.size() != 0) begin
          r = pend_q.pop_front();
          r.stamp = ref_cycle;
          exp_q.push_back(r);
          due_q.push_back(ref_cycle + 32'd3);
        end
      end
      if (trace_valid) begin
        assert (exp_q.size() != 0) else begin
          $display("trace_valid was high with no record expected");
          errors++;
        end
        if (exp_q.size() != 0) begin
          r   = exp_q.pop_front();
          due = due_q.pop_front();
          check_field("arrival cycle", 64'(due), 64'(ref_cycle));
          check_field("trace.stamp", 64'(r.stamp), 64'(trace.stamp));
          check_field("trace.pc", 64'(r.pc), 64'(trace.pc));
          check_field("trace.instr", 64'(r.instr), 64'(trace.instr));
          check_field("trace.mnem", 64'(r.mnem), 64'(trace.mnem));
          check_field("trace.fmt", 64'(r.fmt), 64'(trace.fmt));
          check_field("trace.imm", 64'(r.imm), 64'(trace.imm));
          check_field("trace.target", 64'(r.target), 64'(trace.target));
          check_field("trace.nregs", 64'(r.nregs), 64'(trace.nregs));
          check_field("trace.regs0", 64'(r.regs0), 64'(trace.regs0));
          check_field("trace.regs1", 64'(r.regs1), 64'(trace.regs1));
          check_field("trace.regs2", 64'(r.regs2), 64'(trace.regs2));
          checked++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin : stimulus
    rst_n       <= 1'b0;
    pc          <= '0;
    instr       <= '0;
    id_valid    <= 1'b0;
    is_decoding <= 1'b0;
    pipe_flush  <= 1'b0;
    rs1_value   <= '0;
    rs2_value   <= '0;
    rs3_value   <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // gaps of 0, 1 and 2 idle cycles between captures
    for (int k = 0; k < 10; k++) begin
      send(enc_i(k * 37 - 100, 3'd0, reg_id_t'(k + 1), OPC_OPIMM), MN_ADDI, FMT_I,
           k * 37 - 100);
      repeat (k % 3) idle();
    end
    finish_test("latency and order");

    send(NOP_WORD, MN_NOP, FMT_NONE, 0);
    send(enc_u(20'h12345, OPC_LUI), MN_LUI, FMT_U, 32'h1234_5000);
    send(enc_u(20'hfffff, OPC_AUIPC), MN_AUIPC, FMT_U, 32'hffff_f000);
    send(enc_j(2048), MN_JAL, FMT_UJ, 2048);
    send(enc_i(-4, 3'd0, 5'd1, OPC_JALR), MN_JALR, FMT_I, -4);
    send(enc_b(8, 3'd0, 5'd2, 5'd1), MN_BEQ, FMT_SB, 8);
    send(enc_b(16, 3'd1, 5'd2, 5'd1), MN_BNE, FMT_SB, 16);
    send(enc_b(24, 3'd4, 5'd2, 5'd1), MN_BLT, FMT_SB, 24);
    send(enc_b(32, 3'd5, 5'd2, 5'd1), MN_BGE, FMT_SB, 32);
    send(enc_b(40, 3'd6, 5'd2, 5'd1), MN_BLTU, FMT_SB, 40);
    send(enc_b(48, 3'd7, 5'd2, 5'd1), MN_BGEU, FMT_SB, 48);
    send(enc_i(100, 3'd0, 5'd1, OPC_OPIMM), MN_ADDI, FMT_I, 100);
    send(enc_i(-1, 3'd2, 5'd1, OPC_OPIMM), MN_SLTI, FMT_I, -1);
    send(enc_i(5, 3'd3, 5'd1, OPC_OPIMM), MN_SLTIU, FMT_I, 5);
    send(enc_i(2047, 3'd4, 5'd1, OPC_OPIMM), MN_XORI, FMT_I, 2047);
    send(enc_i(-2048, 3'd6, 5'd1, OPC_OPIMM), MN_ORI, FMT_I, -2048);
    send(enc_i(15, 3'd7, 5'd1, OPC_OPIMM), MN_ANDI, FMT_I, 15);
    send(enc_i(3, 3'd1, 5'd1, OPC_OPIMM), MN_SLLI, FMT_I, 3);
    send(enc_i(4, 3'd5, 5'd1, OPC_OPIMM), MN_SRLI, FMT_I, 4);
    send(enc_i('h404, 3'd5, 5'd1, OPC_OPIMM), MN_SRAI, FMT_I, 'h404);
    send(enc_r(7'h00, 3'd0, 5'd2, 5'd1), MN_ADD, FMT_R, 0);
    send(enc_r(7'h20, 3'd0, 5'd2, 5'd1), MN_SUB, FMT_R, 0);
    send(enc_r(7'h00, 3'd1, 5'd2, 5'd1), MN_SLL, FMT_R, 0);
    send(enc_r(7'h00, 3'd2, 5'd2, 5'd1), MN_SLT, FMT_R, 0);
    send(enc_r(7'h00, 3'd3, 5'd2, 5'd1), MN_SLTU, FMT_R, 0);
    send(enc_r(7'h00, 3'd4, 5'd2, 5'd1), MN_XOR, FMT_R, 0);
    send(enc_r(7'h00, 3'd5, 5'd2, 5'd1), MN_SRL, FMT_R, 0);
    send(enc_r(7'h20, 3'd5, 5'd2, 5'd1), MN_SRA, FMT_R, 0);
    send(enc_r(7'h00, 3'd6, 5'd2, 5'd1), MN_OR, FMT_R, 0);
    send(enc_r(7'h00, 3'd7, 5'd2, 5'd1), MN_AND, FMT_R, 0);
    send(enc_i(0, 3'd0, 5'd0, OPC_FENCE), MN_FENCE, FMT_NONE, 0);
    send(enc_i(0, 3'd1, 5'd0, OPC_FENCE), MN_FENCEI, FMT_NONE, 0);
    send(enc_i('h300, 3'd1, 5'd4, OPC_SYSTEM), MN_CSRRW, FMT_CSR_REG, 'h300);
    send(enc_i('h341, 3'd2, 5'd4, OPC_SYSTEM), MN_CSRRS, FMT_CSR_REG, 'h341);
    send(enc_i('hfff, 3'd3, 5'd4, OPC_SYSTEM), MN_CSRRC, FMT_CSR_REG, 'hfff);
    send(enc_i('h300, 3'd5, 5'd17, OPC_SYSTEM), MN_CSRRWI, FMT_CSR_IMM, 17);
    send(enc_i('h300, 3'd6, 5'd1, OPC_SYSTEM), MN_CSRRSI, FMT_CSR_IMM, 1);
    send(enc_i('h300, 3'd7, 5'd30, OPC_SYSTEM), MN_CSRRCI, FMT_CSR_IMM, 30);
    send(32'h0000_0073, MN_ECALL, FMT_NONE, 0);
    send(32'h0010_0073, MN_EBREAK, FMT_NONE, 0);
    send(32'h1000_0073, MN_ERET, FMT_NONE, 0);
    send(32'h1020_0073, MN_WFI, FMT_NONE, 0);
    send(enc_i(-8, 3'd0, 5'd2, OPC_LOAD), MN_LB, FMT_LOAD, -8);
    send(enc_i(2, 3'd1, 5'd2, OPC_LOAD), MN_LH, FMT_LOAD, 2);
    send(enc_i(4, 3'd2, 5'd2, OPC_LOAD), MN_LW, FMT_LOAD, 4);
    send(enc_i(1, 3'd4, 5'd2, OPC_LOAD), MN_LBU, FMT_LOAD, 1);
    send(enc_i(6, 3'd5, 5'd2, OPC_LOAD), MN_LHU, FMT_LOAD, 6);
    send(enc_s(3, 3'd0, 5'd5, 5'd2), MN_SB, FMT_STORE, 3);
    send(enc_s(-6, 3'd1, 5'd5, 5'd2), MN_SH, FMT_STORE, -6);
    send(enc_s(64, 3'd2, 5'd5, 5'd2), MN_SW, FMT_STORE, 64);
    finish_test("mnemonic and format");

    send(enc_b(-4096, 3'd1, 5'd2, 5'd1), MN_BNE, FMT_SB, -4096);
    send(enc_b(4094, 3'd5, 5'd2, 5'd1), MN_BGE, FMT_SB, 4094);
    send(enc_b(-2, 3'd6, 5'd2, 5'd1), MN_BLTU, FMT_SB, -2);
    send(enc_j(-1048576), MN_JAL, FMT_UJ, -1048576);
    send(enc_j(1048574), MN_JAL, FMT_UJ, 1048574);
    send(enc_u(20'h80000, OPC_LUI), MN_LUI, FMT_U, 32'h8000_0000);
    send(enc_i(-2048, 3'd0, 5'd9, OPC_OPIMM), MN_ADDI, FMT_I, -2048);
    send(enc_s(-1, 3'd2, 5'd3, 5'd4), MN_SW, FMT_STORE, -1);
    send(enc_s(2047, 3'd1, 5'd3, 5'd4), MN_SH, FMT_STORE, 2047);
    send(enc_i('h305, 3'd7, 5'd31, OPC_SYSTEM), MN_CSRRCI, FMT_CSR_IMM, 31);
    finish_test("immediates and targets");

    send(enc_r(7'h00, 3'd0, 5'd17, 5'd31), MN_ADD, FMT_R, 0);
    send(enc_b(12, 3'd0, 5'd0, 5'd30), MN_BEQ, FMT_SB, 12);
    send(enc_i(1, 3'd0, 5'd12, OPC_OPIMM), MN_ADDI, FMT_I, 1);
    send(enc_i(8, 3'd2, 5'd25, OPC_LOAD), MN_LW, FMT_LOAD, 8);
    send(enc_s(12, 3'd2, 5'd9, 5'd30), MN_SW, FMT_STORE, 12);
    send(enc_i('h340, 3'd1, 5'd21, OPC_SYSTEM), MN_CSRRW, FMT_CSR_REG, 'h340);
    send(enc_i('h340, 3'd5, 5'd21, OPC_SYSTEM), MN_CSRRWI, FMT_CSR_IMM, 21);
    send(enc_u(20'h00abc, OPC_AUIPC), MN_AUIPC, FMT_U, 32'h00ab_c000);
    finish_test("register lists");

    send(enc_i(4, 3'd3, 5'd1, OPC_LOAD), MN_INVALID, FMT_NONE, 0);
    send(enc_s(4, 3'd3, 5'd2, 5'd1), MN_INVALID, FMT_NONE, 0);
    send(enc_s(4, 3'd4, 5'd2, 5'd1), MN_INVALID, FMT_NONE, 0);
    // hardware loop setup, then a post-increment load
    send(enc_i(16, 3'd0, 5'd1, 7'b1111011), MN_INVALID, FMT_NONE, 0);
    send(enc_i(4, 3'd2, 5'd1, 7'b0001011), MN_INVALID, FMT_NONE, 0);
    send(enc_r(7'h01, 3'd0, 5'd2, 5'd1), MN_INVALID, FMT_NONE, 0);
    finish_test("invalid encodings");

    flush_mode = 1'b1;
    send(enc_j(-8), MN_JAL, FMT_UJ, -8);
    flush_mode = 1'b0;
    stall();
    stall();
    idle();
    // five in a row keeps the pipeline full
    send(enc_i(7, 3'd0, 5'd3, OPC_OPIMM), MN_ADDI, FMT_I, 7);
    flush_mode = 1'b1;
    send(enc_b(-20, 3'd4, 5'd6, 5'd5), MN_BLT, FMT_SB, -20);
    flush_mode = 1'b0;
    send(enc_s(-100, 3'd0, 5'd8, 5'd7), MN_SB, FMT_STORE, -100);
    send(enc_r(7'h20, 3'd5, 5'd10, 5'd11), MN_SRA, FMT_R, 0);
    send(enc_i(-12, 3'd4, 5'd13, OPC_LOAD), MN_LBU, FMT_LOAD, -12);
    stall();
    send(NOP_WORD, MN_NOP, FMT_NONE, 0);
    finish_test("capture condition");

    $display("total: %0d records checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- trace_capture.sv
// trace capture stage
`timescale 1ns/1ps

module trace_capture import trace_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  word_t pc,
  input  word_t instr,
  input  logic  id_valid,
  input  logic  is_decoding,
  input  logic  pipe_flush,
  input  word_t rs1_value,
  input  word_t rs2_value,
  input  word_t rs3_value,
  output snap_t snap,
  output logic  snap_valid
);

  cycle_t cycle_q;
  logic   capture;

  // accepted in decode, or a flush of the pipeline
  assign capture = (id_valid && is_decoding) || pipe_flush;

  ////////////////////////////////////////
  // free-running cycle counter
  ////////////////////////////////////////
  // zero in the first cycle out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 32'd1;
    end
  end

  ////////////////////////////////////////
  // snapshot register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      snap_valid <= 1'b0;
    end else begin
      snap_valid <= capture;
    end
  end

  // stamp is the count before this edge's increment
  always_ff @(posedge clk) begin
    if (capture) begin
      snap.stamp     <= cycle_q;
      snap.pc        <= pc;
      snap.instr     <= instr;
      snap.rs1_value <= rs1_value;
      snap.rs2_value <= rs2_value;
      snap.rs3_value <= rs3_value;
    end
  end

endmodule

//--- trace_decode.sv
// trace decode stage
`timescale 1ns/1ps

module trace_decode import trace_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  snap_t snap,
  input  logic  snap_valid,
  output dec_t  dec,
  output logic  dec_valid
);

  word_t      instr;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  mnem_t      mnem_d;
  fmt_t       fmt_d;
  word_t      imm_d;

  assign instr  = snap.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  ////////////////////////////////////////
  // mnemonic and operand format
  ////////////////////////////////////////
  always_comb begin
    mnem_d = MN_INVALID;
    fmt_d  = FMT_NONE;
    if (instr == NOP_WORD) begin
      mnem_d = MN_NOP;
    end else begin
      case (opcode)
        OPC_LUI: begin
          mnem_d = MN_LUI;
          fmt_d  = FMT_U;
        end
        OPC_AUIPC: begin
          mnem_d = MN_AUIPC;
          fmt_d  = FMT_U;
        end
        OPC_JAL: begin
          mnem_d = MN_JAL;
          fmt_d  = FMT_UJ;
        end
        OPC_JALR: begin
          if (funct3 == 3'b000) begin
            mnem_d = MN_JALR;
            fmt_d  = FMT_I;
          end
        end
        OPC_BRANCH: begin
          fmt_d = FMT_SB;
          case (funct3)
            3'b000:  mnem_d = MN_BEQ;
            3'b001:  mnem_d = MN_BNE;
            3'b100:  mnem_d = MN_BLT;
            3'b101:  mnem_d = MN_BGE;
            3'b110:  mnem_d = MN_BLTU;
            3'b111:  mnem_d = MN_BGEU;
            default: mnem_d = MN_INVALID;
          endcase
        end
        OPC_OPIMM: begin
          fmt_d = FMT_I;
          case (funct3)
            3'b000: mnem_d = MN_ADDI;
            3'b010: mnem_d = MN_SLTI;
            3'b011: mnem_d = MN_SLTIU;
            3'b100: mnem_d = MN_XORI;
            3'b110: mnem_d = MN_ORI;
            3'b111: mnem_d = MN_ANDI;
            3'b001: mnem_d = (funct7 == 7'h00) ? MN_SLLI : MN_INVALID;
            default: begin
              // shift right, funct7 picks logical or arithmetic
              if (funct7 == 7'h00)      mnem_d = MN_SRLI;
              else if (funct7 == 7'h20) mnem_d = MN_SRAI;
            end
          endcase
        end
        OPC_OP: begin
          fmt_d = FMT_R;
          case ({funct7, funct3})
            10'b0000000_000: mnem_d = MN_ADD;
            10'b0100000_000: mnem_d = MN_SUB;
            10'b0000000_001: mnem_d = MN_SLL;
            10'b0000000_010: mnem_d = MN_SLT;
            10'b0000000_011: mnem_d = MN_SLTU;
            10'b0000000_100: mnem_d = MN_XOR;
            10'b0000000_101: mnem_d = MN_SRL;
            10'b0100000_101: mnem_d = MN_SRA;
            10'b0000000_110: mnem_d = MN_OR;
            10'b0000000_111: mnem_d = MN_AND;
            default:         mnem_d = MN_INVALID;
          endcase
        end
        OPC_FENCE: begin
          if (funct3 == 3'b000)      mnem_d = MN_FENCE;
          else if (funct3 == 3'b001) mnem_d = MN_FENCEI;
        end
        OPC_SYSTEM: begin
          fmt_d = instr[14] ? FMT_CSR_IMM : FMT_CSR_REG;
          case (funct3)
            3'b001: mnem_d = MN_CSRRW;
            3'b010: mnem_d = MN_CSRRS;
            3'b011: mnem_d = MN_CSRRC;
            3'b101: mnem_d = MN_CSRRWI;
            3'b110: mnem_d = MN_CSRRSI;
            3'b111: mnem_d = MN_CSRRCI;
            default: begin
              // privileged words only match exactly
              fmt_d = FMT_NONE;
              case (instr)
                32'h0000_0073: mnem_d = MN_ECALL;
                32'h0010_0073: mnem_d = MN_EBREAK;
                32'h1000_0073: mnem_d = MN_ERET;
                32'h1020_0073: mnem_d = MN_WFI;
                default:       mnem_d = MN_INVALID;
              endcase
            end
          endcase
        end
        OPC_LOAD: begin
          fmt_d = FMT_LOAD;
          case (funct3)
            3'b000:  mnem_d = MN_LB;
            3'b001:  mnem_d = MN_LH;
            3'b010:  mnem_d = MN_LW;
            3'b100:  mnem_d = MN_LBU;
            3'b101:  mnem_d = MN_LHU;
            default: mnem_d = MN_INVALID;
          endcase
        end
        OPC_STORE: begin
          fmt_d = FMT_STORE;
          case (funct3)
            3'b000:  mnem_d = MN_SB;
            3'b001:  mnem_d = MN_SH;
            3'b010:  mnem_d = MN_SW;
            default: mnem_d = MN_INVALID;
          endcase
        end
        default: mnem_d = MN_INVALID;
      endcase
    end
    // invalid words carry no operands
    if (mnem_d == MN_INVALID) fmt_d = FMT_NONE;
  end

  ////////////////////////////////////////
  // immediate by format
  ////////////////////////////////////////
  always_comb begin
    case (fmt_d)
      FMT_U:       imm_d = {instr[31:12], 12'h000};
      FMT_UJ:      imm_d = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      FMT_I,
      FMT_LOAD:    imm_d = {{20{instr[31]}}, instr[31:20]};
      FMT_SB:      imm_d = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      FMT_STORE:   imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      // csr address for the register form
      FMT_CSR_REG: imm_d = {20'h00000, instr[31:20]};
      FMT_CSR_IMM: imm_d = {27'h0, instr[19:15]};
      default:     imm_d = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= snap_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (snap_valid) begin
      dec.snap <= snap;
      dec.mnem <= mnem_d;
      dec.fmt  <= fmt_d;
      dec.imm  <= imm_d;
    end
  end

endmodule

//--- trace_pack.sv
// trace record packing stage
`timescale 1ns/1ps

module trace_pack import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  dec_t       dec,
  input  logic       dec_valid,
  output trace_rec_t trace,
  output logic       trace_valid
);

  reg_entry_t rs1_entry;
  reg_entry_t rs2_entry;
  trace_rec_t rec_d;

  // source indices straight from the instruction word
  assign rs1_entry.id    = dec.snap.instr[19:15];
  assign rs1_entry.value = dec.snap.rs1_value;
  assign rs2_entry.id    = dec.snap.instr[24:20];
  assign rs2_entry.value = dec.snap.rs2_value;

  ////////////////////////////////////////
  // record assembly
  ////////////////////////////////////////
  always_comb begin
    rec_d.stamp  = dec.snap.stamp;
    rec_d.pc     = dec.snap.pc;
    rec_d.instr  = dec.snap.instr;
    rec_d.mnem   = dec.mnem;
    rec_d.fmt    = dec.fmt;
    rec_d.imm    = dec.imm;
    rec_d.nregs  = 2'd0;
    rec_d.regs0  = '0;
    rec_d.regs1  = '0;
    // third slot is for reg-reg stores, never filled by RV32I
    rec_d.regs2  = '0;

    // register list in the order the tracer prints it
    case (dec.fmt)
      FMT_R,
      FMT_SB: begin
        rec_d.nregs = 2'd2;
        rec_d.regs0 = rs1_entry;
        rec_d.regs1 = rs2_entry;
      end
      FMT_I,
      FMT_CSR_REG,
      FMT_LOAD: begin
        rec_d.nregs = 2'd1;
        rec_d.regs0 = rs1_entry;
      end
      FMT_STORE: begin
        // data register first, then the base
        rec_d.nregs = 2'd2;
        rec_d.regs0 = rs2_entry;
        rec_d.regs1 = rs1_entry;
      end
      default: rec_d.nregs = 2'd0;
    endcase

    // branch and jump destinations
    if (dec.fmt == FMT_SB || dec.fmt == FMT_UJ) begin
      rec_d.target = dec.snap.pc + dec.imm;
    end else begin
      rec_d.target = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) trace <= rec_d;
  end

endmodule

//--- trace_pkg.sv
// instruction trace unit definitions
package trace_pkg;

  ////////////////////////////////////////
  // widths that carry a meaning
  ////////////////////////////////////////
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_id_t;
  typedef logic [31:0] cycle_t;
  typedef logic [6:0]  opcode_t;

  // RV32I major opcodes
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OPIMM  = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_FENCE  = 7'b0001111;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  // addi x0, x0, 0
  localparam word_t NOP_WORD = 32'h0000_0013;

  // most register entries in one record
  localparam int unsigned MAX_REGS = 3;

  ////////////////////////////////////////
  // operand format and mnemonic
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    FMT_NONE, FMT_U, FMT_UJ, FMT_I, FMT_SB,
    FMT_R, FMT_CSR_REG, FMT_CSR_IMM, FMT_LOAD, FMT_STORE
  } fmt_t;

  typedef enum logic [5:0] {
    MN_NOP,
    MN_LUI, MN_AUIPC, MN_JAL, MN_JALR,
    MN_BEQ, MN_BNE, MN_BLT, MN_BGE, MN_BLTU, MN_BGEU,
    MN_ADDI, MN_SLTI, MN_SLTIU, MN_XORI, MN_ORI, MN_ANDI,
    MN_SLLI, MN_SRLI, MN_SRAI,
    MN_ADD, MN_SUB, MN_SLL, MN_SLT, MN_SLTU,
    MN_XOR, MN_SRL, MN_SRA, MN_OR, MN_AND,
    MN_FENCE, MN_FENCEI,
    MN_CSRRW, MN_CSRRS, MN_CSRRC, MN_CSRRWI, MN_CSRRSI, MN_CSRRCI,
    MN_ECALL, MN_EBREAK, MN_ERET, MN_WFI,
    MN_LB, MN_LH, MN_LW, MN_LBU, MN_LHU,
    MN_SB, MN_SH, MN_SW,
    MN_INVALID
  } mnem_t;

  ////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////
  typedef struct packed {
    reg_id_t id;
    word_t   value;
  } reg_entry_t;

  typedef struct packed {
    cycle_t stamp;
    word_t  pc;
    word_t  instr;
    word_t  rs1_value;
    word_t  rs2_value;
    word_t  rs3_value;
  } snap_t;

  typedef struct packed {
    snap_t snap;
    mnem_t mnem;
    fmt_t  fmt;
    word_t imm;
  } dec_t;

  // unused register entries are all zero
  typedef struct packed {
    cycle_t     stamp;
    word_t      pc;
    word_t      instr;
    mnem_t      mnem;
    fmt_t       fmt;
    word_t      imm;
    word_t      target;
    logic [1:0] nregs;
    reg_entry_t regs0;
    reg_entry_t regs1;
    reg_entry_t regs2;
  } trace_rec_t;

endpackage

//--- trace_unit_properties.sv
// trace unit protocol assertions
`timescale 1ns/1ps

module trace_unit_properties import trace_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       id_valid,
  input logic       is_decoding,
  input logic       pipe_flush,
  input logic       snap_valid,
  input logic       dec_valid,
  input logic       trace_valid,
  input trace_rec_t trace
);

  logic capture;

  assign capture = (id_valid && is_decoding) || pipe_flush;

  ////////////////////////////////////////
  // record timing
  ////////////////////////////////////////
  // every capture leaves as a record three edges later
  a_capture_to_record: assert property (
    @(posedge clk) disable iff (!rst_n)
      capture |-> ##3 trace_valid
  ) else $error("trace_valid missing three cycles after a capture");

  // and no record leaves without its capture
  a_record_from_capture: assert property (
    @(posedge clk) disable iff (!rst_n)
      trace_valid |-> $past(capture, 3)
  ) else $error("trace_valid without a capture three cycles earlier");

  ////////////////////////////////////////
  // record contents and reset
  ////////////////////////////////////////
  // entries past nregs stay zero
  a_nregs_limit: assert property (
    @(posedge clk) disable iff (!rst_n)
      trace_valid |-> (32'(trace.nregs) <= MAX_REGS) &&
                      (trace.nregs > 2'd0 || trace.regs0 == '0) &&
                      (trace.nregs > 2'd1 || trace.regs1 == '0) &&
                      (trace.nregs > 2'd2 || trace.regs2 == '0)
  ) else $error("register list does not match its entry count");

  // all stage strobes stay low in reset
  a_quiet_in_reset: assert property (
    @(posedge clk)
      !rst_n |-> !(snap_valid || dec_valid || trace_valid)
  ) else $error("valid strobe high while reset is asserted");

endmodule

bind trace_unit_top trace_unit_properties i_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .id_valid    (id_valid),
  .is_decoding (is_decoding),
  .pipe_flush  (pipe_flush),
  .snap_valid  (snap_valid),
  .dec_valid   (dec_valid),
  .trace_valid (trace_valid),
  .trace       (trace)
);

//--- trace_unit_top.sv
// instruction trace unit top level
`timescale 1ns/1ps

module trace_unit_top import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  word_t      pc,
  input  word_t      instr,
  input  logic       id_valid,
  input  logic       is_decoding,
  input  logic       pipe_flush,
  input  word_t      rs1_value,
  input  word_t      rs2_value,
  input  word_t      rs3_value,
  output trace_rec_t trace,
  output logic       trace_valid
);

  snap_t snap;
  logic  snap_valid;
  dec_t  dec;
  logic  dec_valid;

  ////////////////////////////////////////
  // capture -> decode -> pack
  ////////////////////////////////////////
  trace_capture u_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc          (pc),
    .instr       (instr),
    .id_valid    (id_valid),
    .is_decoding (is_decoding),
    .pipe_flush  (pipe_flush),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .rs3_value   (rs3_value),
    .snap        (snap),
    .snap_valid  (snap_valid)
  );

  trace_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .snap       (snap),
    .snap_valid (snap_valid),
    .dec        (dec),
    .dec_valid  (dec_valid)
  );

  trace_pack u_pack (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec         (dec),
    .dec_valid   (dec_valid),
    .trace       (trace),
    .trace_valid (trace_valid)
  );

endmodule
